// File: verilog/sum_pkg.sv
////////////////////
// Shared widths, unit count and result address layout for the sum cluster
// Result word packs vertex id, unit number and sum, msb first
////////////////////

package sum_pkg;

	////////////////////
	// Cluster size and data widths
	////////////////////
	localparam int NUM_CU   = 2;
	localparam int DATA_W   = 32;
	localparam int VERTEX_W = 8;
	localparam int DEGREE_W = 8;
	localparam int CU_ID_W  = 1;
	localparam int ADDR_W   = 16;

	////////////////////
	// Result memory layout
	////////////////////
	// Base of result region, one 1 KB window per unit
	localparam logic [ADDR_W-1:0] RESULT_BASE = 16'h1000;
	localparam int CU_ADDR_SHIFT     = 10;
	// One 32-bit word per vertex
	localparam int VERTEX_ADDR_SHIFT = 2;

	// Queued result fields, sum in the low bits
	localparam int RESULT_W    = VERTEX_W + CU_ID_W + DATA_W;
	localparam int RES_CU_LSB  = DATA_W;
	localparam int RES_VID_LSB = DATA_W + CU_ID_W;

	// Result queue sizing
	localparam int RESULT_FIFO_DEPTH = 4;
	// Leaves room for the two edges still in flight
	localparam int ALMOST_FULL_LEVEL = 2;

	// APB requester states
	typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_e;

endpackage

// File: verilog/sync_fifo.sv
////////////////////
// Head is shown combinationally on data_out
// Push while full and pop while empty are dropped and flagged
////////////////////
`timescale 1ns/100ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty,
	output logic             full,
	output logic             almost_full
);
	import sum_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             wr_en;
	logic             rd_en;

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	// Storage, written only on an accepted push
	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_ptr] <= data_in;
		end
	end

	////////////////////
	// Pointers and occupancy
	////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves count unchanged
			if (wr_en && !rd_en) begin
				count <= count + 1'b1;
			end else if (rd_en && !wr_en) begin
				count <= count - 1'b1;
			end
		end
	end

	assign data_out    = mem[rd_ptr];
	assign empty       = (count == '0);
	assign full        = (count == CNT_W'(DEPTH));
	assign almost_full = (count >= CNT_W'(ALMOST_FULL_LEVEL));

	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn) !(push && full));
	a_no_underflow: assert property (@(posedge clock) disable iff (!rstn) !(pop && empty));

endmodule

// File: verilog/sum_kernel_control.sv
////////////////////
// One vertex job at a time, source holds it until vertex_done
// Enable acts one cycle late and freezes every register but edge_ready
////////////////////
`timescale 1ns/100ps

module sum_kernel_control #(
	parameter int CU_ID = 0
) (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enable,
	input  logic                          vertex_valid,
	input  logic [sum_pkg::VERTEX_W-1:0]  vertex_id,
	input  logic [sum_pkg::DEGREE_W-1:0]  vertex_degree,
	input  logic                          edge_valid,
	input  logic [sum_pkg::DATA_W-1:0]    edge_data,
	input  logic                          result_pop,
	output logic                          edge_ready,
	output logic                          vertex_done,
	output logic                          result_valid,
	output logic [sum_pkg::RESULT_W-1:0]  result_data
);
	import sum_pkg::*;

	logic                enabled;
	logic                job_valid;
	logic [VERTEX_W-1:0] job_id;
	logic [DEGREE_W-1:0] job_degree;
	logic [DEGREE_W-1:0] edges_taken;
	logic                edge_lat_valid;
	logic [DATA_W-1:0]   edge_lat;
	logic [DATA_W-1:0]   sum;
	logic [DEGREE_W-1:0] sum_count;
	logic                accept;
	logic                done;
	logic                fifo_empty;
	logic                fifo_full;
	logic                fifo_almost_full;
	// Next-state view of the job, feeds registered edge_ready
	logic                job_valid_d;
	logic [VERTEX_W-1:0] job_id_d;
	logic [DEGREE_W-1:0] job_degree_d;
	logic [DEGREE_W-1:0] taken_d;

	assign accept = edge_valid && edge_ready;
	// All edges added, and room to queue the result
	assign done   = enabled && job_valid && (sum_count == job_degree) && !fifo_full;

	always_comb begin
		job_valid_d  = job_valid;
		job_id_d     = job_id;
		job_degree_d = job_degree;
		taken_d      = edges_taken;
		if (enabled) begin
			if (done) begin
				// Skip one cycle so a stale vertex_valid is not relatched
				job_valid_d = 1'b0;
				taken_d     = '0;
			end else begin
				job_valid_d  = vertex_valid;
				job_id_d     = vertex_id;
				job_degree_d = vertex_degree;
				taken_d      = edges_taken + DEGREE_W'(accept);
			end
		end
	end

	////////////////////
	// Enable, job and edge_ready registers
	////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled     <= 1'b0;
			job_valid   <= 1'b0;
			job_id      <= '0;
			job_degree  <= '0;
			edges_taken <= '0;
			edge_ready  <= 1'b0;
		end else begin
			enabled     <= enable;
			job_valid   <= job_valid_d;
			job_id      <= job_id_d;
			job_degree  <= job_degree_d;
			edges_taken <= taken_d;
			// Raw enable here so ready is low from the second frozen cycle
			edge_ready  <= enable && job_valid_d && (taken_d < job_degree_d) && !fifo_almost_full;
		end
	end

	////////////////////
	// Edge latch and accumulate
	////////////////////
	always_ff @(posedge clock) begin
		if (enabled && accept) begin
			edge_lat <= edge_data;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_lat_valid <= 1'b0;
			sum            <= '0;
			sum_count      <= '0;
		end else if (enabled) begin
			edge_lat_valid <= accept;
			if (done) begin
				sum       <= '0;
				sum_count <= '0;
			end else if (edge_lat_valid) begin
				// Wraps at 32 bits
				sum       <= sum + edge_lat;
				sum_count <= sum_count + 1'b1;
			end
		end
	end

	assign vertex_done  = done;
	assign result_valid = !fifo_empty;

	// Result queue towards the arbiter
	sync_fifo #(
		.WIDTH(RESULT_W),
		.DEPTH(RESULT_FIFO_DEPTH)
	) i_result_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (done),
		.data_in    ({job_id, CU_ID_W'(CU_ID), sum}),
		.pop        (result_pop),
		.data_out   (result_data),
		.empty      (fifo_empty),
		.full       (fifo_full),
		.almost_full(fifo_almost_full)
	);

	// A latched edge always belongs to a job that still owes edges
	a_no_excess_edge: assert property (@(posedge clock) disable iff (!rstn)
		edge_lat_valid |-> job_valid && (sum_count < job_degree));

endmodule

// File: verilog/result_bus_arbiter.sv
////////////////////
// Round-robin over unit queues, one APB write per result, pwrite fixed high
// pslverr only raises a warning
////////////////////
`timescale 1ns/100ps

module result_bus_arbiter (
	input  logic                                            clock,
	input  logic                                            rstn,
	input  logic [sum_pkg::NUM_CU-1:0]                      result_valid,
	input  logic [sum_pkg::NUM_CU-1:0][sum_pkg::RESULT_W-1:0] result_data,
	input  logic                                            pready,
	input  logic                                            pslverr,
	output logic [sum_pkg::NUM_CU-1:0]                      result_pop,
	output logic                                            psel,
	output logic                                            penable,
	output logic                                            pwrite,
	output logic [sum_pkg::ADDR_W-1:0]                      paddr,
	output logic [sum_pkg::DATA_W-1:0]                      pwdata
);
	import sum_pkg::*;

	apb_state_e          state;
	logic [CU_ID_W-1:0]  last_grant;
	logic [CU_ID_W-1:0]  pick;
	logic                pick_valid;
	logic [RESULT_W-1:0] head;
	logic [ADDR_W-1:0]   head_addr;

	// First valid unit after the last grant
	always_comb begin
		logic [CU_ID_W-1:0] cand;
		pick_valid = 1'b0;
		pick       = last_grant;
		for (int i = 1; i <= NUM_CU; i++) begin
			cand = CU_ID_W'((int'(last_grant) + i) % NUM_CU);
			if (!pick_valid && result_valid[cand]) begin
				pick_valid = 1'b1;
				pick       = cand;
			end
		end
	end

	// Address from the unit and vertex fields of the head
	assign head      = result_data[pick];
	assign head_addr = RESULT_BASE
		+ (ADDR_W'(head[RES_CU_LSB +: CU_ID_W]) << CU_ADDR_SHIFT)
		+ (ADDR_W'(head[RES_VID_LSB +: VERTEX_W]) << VERTEX_ADDR_SHIFT);

	////////////////////
	// APB requester FSM
	////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= IDLE;
			last_grant <= CU_ID_W'(NUM_CU - 1);
			result_pop <= '0;
			psel       <= 1'b0;
			penable    <= 1'b0;
		end else begin
			result_pop <= '0;
			case (state)
				IDLE: if (pick_valid) begin
					state            <= SETUP;
					last_grant       <= pick;
					// Pop lands in the SETUP cycle
					result_pop[pick] <= 1'b1;
					psel             <= 1'b1;
				end
				SETUP: begin
					state   <= ACCESS;
					penable <= 1'b1;
				end
				ACCESS: if (pready) begin
					state   <= IDLE;
					psel    <= 1'b0;
					penable <= 1'b0;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Holding register for the granted head
	always_ff @(posedge clock) begin
		if (state == IDLE && pick_valid) begin
			paddr  <= head_addr;
			pwdata <= head[DATA_W-1:0];
		end
	end

	assign pwrite = 1'b1;

	a_apb_stable: assert property (@(posedge clock) disable iff (!rstn)
		psel && !(penable && pready) |=> $stable(paddr) && $stable(pwdata));
	a_one_pop: assert property (@(posedge clock) disable iff (!rstn) $onehot0(result_pop));
	a_no_slverr: assert property (@(posedge clock) disable iff (!rstn) !(pslverr && pready))
		else $warning("pslverr seen on completed write");

endmodule

// File: verilog/sum_kernel_cluster.sv
////////////////////
// Per-unit ports are vectors indexed by unit number
////////////////////
`timescale 1ns/100ps

module sum_kernel_cluster (
	input  logic                                             clock,
	input  logic                                             rstn,
	input  logic                                             enable,
	// Vertex jobs
	input  logic [sum_pkg::NUM_CU-1:0]                       vertex_valid,
	input  logic [sum_pkg::NUM_CU-1:0][sum_pkg::VERTEX_W-1:0] vertex_id,
	input  logic [sum_pkg::NUM_CU-1:0][sum_pkg::DEGREE_W-1:0] vertex_degree,
	// Edge streams
	input  logic [sum_pkg::NUM_CU-1:0]                       edge_valid,
	input  logic [sum_pkg::NUM_CU-1:0][sum_pkg::DATA_W-1:0]  edge_data,
	output logic [sum_pkg::NUM_CU-1:0]                       edge_ready,
	output logic [sum_pkg::NUM_CU-1:0]                       vertex_done,
	// APB requester
	output logic                                             psel,
	output logic                                             penable,
	output logic                                             pwrite,
	output logic [sum_pkg::ADDR_W-1:0]                       paddr,
	output logic [sum_pkg::DATA_W-1:0]                       pwdata,
	input  logic                                             pready,
	input  logic                                             pslverr
);
	import sum_pkg::*;

	logic [NUM_CU-1:0]               result_valid;
	logic [NUM_CU-1:0][RESULT_W-1:0] result_data;
	logic [NUM_CU-1:0]               result_pop;

	////////////////////
	// Compute units
	////////////////////
	for (genvar g = 0; g < NUM_CU; g++) begin : g_cu
		sum_kernel_control #(
			.CU_ID(g)
		) i_cu (
			.clock        (clock),
			.rstn         (rstn),
			.enable       (enable),
			.vertex_valid (vertex_valid[g]),
			.vertex_id    (vertex_id[g]),
			.vertex_degree(vertex_degree[g]),
			.edge_valid   (edge_valid[g]),
			.edge_data    (edge_data[g]),
			.result_pop   (result_pop[g]),
			.edge_ready   (edge_ready[g]),
			.vertex_done  (vertex_done[g]),
			.result_valid (result_valid[g]),
			.result_data  (result_data[g])
		);
	end

	// Shared result bus
	result_bus_arbiter i_arbiter (
		.clock       (clock),
		.rstn        (rstn),
		.result_valid(result_valid),
		.result_data (result_data),
		.pready      (pready),
		.pslverr     (pslverr),
		.result_pop  (result_pop),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata)
	);

endmodule

// File: dv/tb_sum_kernel_cluster.sv
////////////////////
// Both units run jobs in phases, APB completer stalls at random
// Expected sums are keyed by result address, ids unique per unit
////////////////////
`timescale 1ns/100ps

module tb_sum_kernel_cluster;
	import sum_pkg::*;

	localparam int CLK_PERIOD     = 100;
	localparam int DRIVE_DELAY    = 10;
	localparam int MAX_JOBS       = 40;
	localparam int CYCLES_PER_JOB = 40;
	localparam int HOLD_CYCLES    = 150;
	localparam int FREEZE_CYCLES  = 20;

	logic                            clock;
	logic                            rstn;
	logic                            enable;
	logic [NUM_CU-1:0]               vertex_valid;
	logic [NUM_CU-1:0][VERTEX_W-1:0] vertex_id;
	logic [NUM_CU-1:0][DEGREE_W-1:0] vertex_degree;
	logic [NUM_CU-1:0]               edge_valid;
	logic [NUM_CU-1:0][DATA_W-1:0]   edge_data;
	logic [NUM_CU-1:0]               edge_ready;
	logic [NUM_CU-1:0]               vertex_done;
	logic                            psel;
	logic                            penable;
	logic                            pwrite;
	logic [ADDR_W-1:0]               paddr;
	logic [DATA_W-1:0]               pwdata;
	logic                            pready;
	logic                            pslverr;

	logic [31:0]       lfsr;
	logic              hold_pready;
	logic              last_unit;
	logic              both_pending;
	int                errors;
	int                jobs_done;
	int                writes_done;
	// Expected sum and write count per result address
	logic [DATA_W-1:0] exp_sum [logic [ADDR_W-1:0]];
	int                write_count [logic [ADDR_W-1:0]];
	bit                id_used [NUM_CU][256];

	sum_kernel_cluster i_dut (
		.clock        (clock),
		.rstn         (rstn),
		.enable       (enable),
		.vertex_valid (vertex_valid),
		.vertex_id    (vertex_id),
		.vertex_degree(vertex_degree),
		.edge_valid   (edge_valid),
		.edge_data    (edge_data),
		.edge_ready   (edge_ready),
		.vertex_done  (vertex_done),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.pready       (pready),
		.pslverr      (pslverr)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	////////////////////
	// Helpers
	////////////////////
	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [VERTEX_W-1:0] new_id(input int u);
		logic [VERTEX_W-1:0] id;
		id = VERTEX_W'(rand_bits(VERTEX_W));
		while (id_used[u][id]) begin
			id = VERTEX_W'(rand_bits(VERTEX_W));
		end
		id_used[u][id] = 1'b1;
		return id;
	endfunction

	// Base, then 1 KB per unit, then one word per vertex
	function automatic logic [ADDR_W-1:0] result_addr(input int u, input logic [VERTEX_W-1:0] id);
		return RESULT_BASE + ADDR_W'(u * 1024 + int'(id) * 4);
	endfunction

	// Called a few ns after a rising edge, returns at the same point
	task automatic run_job(input int u, input logic [VERTEX_W-1:0] id,
			input logic [DEGREE_W-1:0] deg);
		int                sent;
		logic [DATA_W-1:0] total;
		logic              finished;
		logic              accepted;
		sent             = 0;
		total            = '0;
		finished         = 1'b0;
		vertex_valid[u]  = 1'b1;
		vertex_id[u]     = id;
		vertex_degree[u] = deg;
		while (!finished) begin
			// Next edge, unless a gap is drawn
			if (!edge_valid[u] && sent < int'(deg) && rand_bits(2) != 0) begin
				edge_valid[u] = 1'b1;
				edge_data[u]  = rand_bits(DATA_W);
			end
			@(negedge clock);
			accepted = edge_valid[u] && edge_ready[u];
			if (accepted) begin
				total = total + edge_data[u];
				sent++;
			end
			if (vertex_done[u]) begin
				finished = 1'b1;
				a_all_edges: assert (sent == int'(deg)) else begin
					errors++;
					$display("** Error edges sent, unit %0d vertex %h: got %h, expected %h",
						u, id, sent, deg);
				end
				exp_sum[result_addr(u, id)] = total;
				jobs_done++;
			end
			@(posedge clock);
			#DRIVE_DELAY;
			if (accepted) begin
				edge_valid[u] = 1'b0;
			end
		end
	endtask

	// Degree drawn from lo..hi
	task automatic unit_jobs(input int u, input int n, input int lo, input int hi);
		logic [DEGREE_W-1:0] deg;
		for (int j = 0; j < n; j++) begin
			deg = DEGREE_W'(lo + int'(rand_bits(3)) % (hi - lo + 1));
			run_job(u, new_id(u), deg);
		end
		vertex_valid[u] = 1'b0;
	endtask

	////////////////////
	// APB completer
	////////////////////
	initial begin
		pready  = 1'b0;
		pslverr = 1'b0;
		forever begin
			@(posedge clock);
			#DRIVE_DELAY;
			if (hold_pready) begin
				pready = 1'b0;
			end else begin
				pready = (rand_bits(2) != 2'b00);
			end
		end
	end

	always @(negedge clock) begin
		logic [ADDR_W-1:0] offset;
		logic              unit;
		if (rstn) begin
			offset = paddr - RESULT_BASE;
			unit   = (offset >= ADDR_W'(1024));
			// First cycle of a grant
			if (psel && !penable) begin
				if (both_pending) begin
					a_alternate: assert (unit != last_unit) else begin
						errors++;
						$display("** Error paddr unit: got %h, expected %h", unit, !last_unit);
					end
				end
				last_unit = unit;
			end
			both_pending = !psel && (&i_dut.result_valid);
			// Write completes on the coming rising edge
			if (psel && penable && pready) begin
				if (!exp_sum.exists(paddr)) begin
					errors++;
					$display("Write to address %h matches no finished job", paddr);
				end else begin
					a_sum: assert (pwdata == exp_sum[paddr]) else begin
						errors++;
						$display("** Error pwdata at %h: got %h, expected %h",
							paddr, pwdata, exp_sum[paddr]);
					end
				end
				if (write_count.exists(paddr)) begin
					write_count[paddr]++;
				end else begin
					write_count[paddr] = 1;
				end
				writes_done++;
			end
		end
	end

	////////////////////
	// Protocol and freeze checks
	////////////////////
	a_setup_first: assert property (@(posedge clock) disable iff (!rstn)
		$rose(penable) |-> $past(psel && !penable)) else begin
		errors++;
		$display("penable rose without a SETUP cycle before it");
	end
	a_penable_psel: assert property (@(posedge clock) disable iff (!rstn) penable |-> psel)
		else begin
		errors++;
		$display("** Error psel: got %h with penable high, expected 1", psel);
	end
	a_addr_stable: assert property (@(posedge clock) disable iff (!rstn)
		psel && !(penable && pready) |=> $stable(paddr) && $stable(pwdata)) else begin
		errors++;
		$display("** Error paddr %h pwdata %h changed before pready", paddr, pwdata);
	end
	a_pwrite: assert property (@(posedge clock) disable iff (!rstn) psel |-> pwrite) else begin
		errors++;
		$display("** Error pwrite: got %h, expected 1", pwrite);
	end
	a_freeze: assert property (@(posedge clock) disable iff (!rstn)
		!enable |=> edge_ready == '0 && vertex_done == '0) else begin
		errors++;
		$display("** Error frozen: edge_ready %h vertex_done %h, expected 0", edge_ready,
			vertex_done);
	end
	a_sum_frozen0: assert property (@(posedge clock) disable iff (!rstn)
		!enable && !$past(enable) |=> $stable(i_dut.g_cu[0].i_cu.sum)) else begin
		errors++;
		$display("** Error unit 0 sum changed while frozen: %h", i_dut.g_cu[0].i_cu.sum);
	end
	a_sum_frozen1: assert property (@(posedge clock) disable iff (!rstn)
		!enable && !$past(enable) |=> $stable(i_dut.g_cu[1].i_cu.sum)) else begin
		errors++;
		$display("** Error unit 1 sum changed while frozen: %h", i_dut.g_cu[1].i_cu.sum);
	end
	a_zero_deg0: assert property (@(posedge clock) disable iff (!rstn)
		vertex_valid[0] && vertex_degree[0] == '0 |-> !edge_ready[0]) else begin
		errors++;
		$display("** Error edge_ready[0]: got %h for degree 0, expected 0", edge_ready[0]);
	end
	a_zero_deg1: assert property (@(posedge clock) disable iff (!rstn)
		vertex_valid[1] && vertex_degree[1] == '0 |-> !edge_ready[1]) else begin
		errors++;
		$display("** Error edge_ready[1]: got %h for degree 0, expected 0", edge_ready[1]);
	end

	// Watchdog sized for the longest job mix
	initial begin
		#(MAX_JOBS * NUM_CU * CYCLES_PER_JOB * CLK_PERIOD);
		$display("Timeout: %0d of %0d results written, run stopped", writes_done, jobs_done);
		$display("CHECKS FAILED");
		$finish;
	end

	////////////////////
	// Main sequence
	////////////////////
	initial begin
		lfsr          = 32'hb67d_e0c2;
		errors        = 0;
		jobs_done     = 0;
		writes_done   = 0;
		hold_pready   = 1'b0;
		last_unit     = 1'b1;
		both_pending  = 1'b0;
		rstn          = 1'b0;
		enable        = 1'b1;
		vertex_valid  = '0;
		vertex_id     = '0;
		vertex_degree = '0;
		edge_valid    = '0;
		edge_data     = '0;
		repeat (4) @(posedge clock);
		a_reset_idle: assert (!psel && !penable && edge_ready == '0 && vertex_done == '0)
			else begin
			errors++;
			$display("** Error in reset: psel %h penable %h edge_ready %h vertex_done %h",
				psel, penable, edge_ready, vertex_done);
		end
		#DRIVE_DELAY;
		rstn = 1'b1;

		// Degree-zero jobs
		fork
			unit_jobs(0, 1, 0, 0);
			unit_jobs(1, 1, 0, 0);
		join
		// Random jobs, bus mostly ready
		fork
			unit_jobs(0, 16, 0, 7);
			unit_jobs(1, 16, 0, 7);
		join
		// Long pready stall, queues fill and edges stop
		fork
			unit_jobs(0, 8, 1, 7);
			unit_jobs(1, 8, 1, 7);
			begin
				@(negedge clock);
				hold_pready = 1'b1;
				repeat (HOLD_CYCLES) @(negedge clock);
				a_stalled: assert (edge_ready == '0) else begin
					errors++;
					$display("** Error edge_ready under stall: got %h, expected 0", edge_ready);
				end
				hold_pready = 1'b0;
			end
		join
		// Freeze in the middle of jobs
		fork
			unit_jobs(0, 6, 1, 7);
			unit_jobs(1, 6, 1, 7);
			begin
				repeat (15) @(posedge clock);
				#DRIVE_DELAY;
				enable = 1'b0;
				repeat (FREEZE_CYCLES) @(posedge clock);
				#DRIVE_DELAY;
				enable = 1'b1;
			end
		join

		// Drain the result bus
		while (writes_done < jobs_done) begin
			@(negedge clock);
		end
		repeat (4) @(negedge clock);
		foreach (exp_sum[a]) begin
			if (!write_count.exists(a) || write_count[a] != 1) begin
				errors++;
				$display("Result for address %h was not written exactly once", a);
			end
		end

		$display("Summary: %0d jobs, %0d writes, %0d errors", jobs_done, writes_done, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
verilog/sum_pkg.sv
verilog/sync_fifo.sv
verilog/sum_kernel_control.sv
verilog/result_bus_arbiter.sv
verilog/sum_kernel_cluster.sv
dv/tb_sum_kernel_cluster.sv

// File: run.sh
#!/bin/sh
# Build and run the cluster testbench with Verilator
# The run passes only if sim.log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module tb_sum_kernel_cluster -o sim > sim.log 2>&1 &&
	./obj_dir/sim >> sim.log 2>&1

grep -q "^ALL CHECKS PASSED$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
